//--- project.f
+incdir+source
source/cadr_pkg.sv
source/micro_if.sv
source/control_store.sv
source/instr_queue.sv
source/micro_exec.sv
source/cadr_core.sv
sim/cadr_assert.sv
sim/cadr_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run into sim.log, then look for the pass line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
   --top-module cadr_tb -f project.f -o cadr_sim \
   && ./obj_dir/cadr_sim > sim.log 2>&1
grep -qx "No errors" sim.log && echo "Simulation passed" || { echo "Simulation failed, see sim.log"; exit 1; }

//--- sim/cadr_assert.sv
// Protocol checks on the queue links and the result port; bound into the core at the end of this file
`include "cadr_consts.svh"

module cadr_assert (
   input logic                                   clk,
   input logic                                   reset,
   input logic                                   fetch_valid,
   input logic                                   issue_valid,
   input logic                                   issue_credit,
   input logic [$clog2(`CADR_QUEUE_DEPTH+1)-1:0] q_count,
   input logic                                   result_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   int held;   // Words the consumer holds, counted from the link

   always_ff @(posedge clk) begin
      if (reset) begin
         held <= 0;
      end else begin
         held <= held + int'(issue_valid) - int'(issue_credit);
      end
   end

   ////////////////////
   // Credit links

   no_overflow: assert property (@(posedge clk) disable iff (reset)
      fetch_valid |-> (q_count != `CADR_QUEUE_DEPTH))   // Store spends only real credits
      else $error("Word pushed into a full queue");

   no_free_issue: assert property (@(posedge clk) disable iff (reset)
      issue_valid |-> ((held - int'(issue_credit)) < `CADR_EXEC_SLOTS))   // Freed slot counts at once
      else $error("Word issued without an execution credit");

   ////////////////////
   // Result port

   quiet_in_reset: assert property (@(posedge clk)
      $past(reset) |-> !result_valid)
      else $error("Result valid while in reset");

   // Three quiet cycles before each pulse, one word per microcycle
   result_spacing: assert property (@(posedge clk) disable iff (reset)
      result_valid |-> !$past(result_valid, 1) && !$past(result_valid, 2)
                       && !$past(result_valid, 3))
      else $error("Results closer than one microcycle apart");

endmodule

bind cadr_core cadr_assert u_cadr_assert (
   .clk          (clk),
   .reset        (reset),
   .fetch_valid  (fetch_link.valid),
   .issue_valid  (issue_link.valid),
   .issue_credit (issue_link.credit),
   .q_count      (u_instr_queue.count),
   .result_valid (result_valid)
);

//--- sim/cadr_tb.sv
// Testbench for the microcoded core; loads programs, runs them and checks every result against a model
`include "cadr_consts.svh"

module cadr_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int PERIOD       = 40;
   localparam int RESET_CYCLES = 4;
   localparam int CPI          = `CADR_CYCLES_PER_INSTR;
   localparam int REGS         = 1 << `CADR_ADDR_W;
   localparam int LEN_LOADI    = 16;   // Immediate loads
   localparam int LEN_PRELOAD  = 16;   // Register setup for the random run
   localparam int LEN_RANDOM   = 48;
   localparam int LEN_CHAIN    = 12;
   localparam int LEN_BURST    = 64;   // Whole control store
   localparam int LEN_ABORT    = 32;   // Cut short by reset
   localparam int LEN_ZERO     = 8;
   localparam int LEN_RELOAD   = 10;
   localparam int RUNS         = 8;
   localparam int ALL_WORDS    = LEN_LOADI + LEN_PRELOAD + LEN_RANDOM + LEN_CHAIN
                                 + LEN_BURST + LEN_ABORT + LEN_ZERO + LEN_RELOAD;
   // Loading costs a cycle a word, then CPI cycles a word plus startup
   localparam int LIMIT_CYCLES = ALL_WORDS * (CPI + 1) + RUNS * 20;

   typedef struct packed {
      logic                    dest_m;
      logic [`CADR_ADDR_W-1:0] addr;
      logic [`CADR_DATA_W-1:0] data;
      logic [`CADR_PC_W-1:0]   pc;
   } expect_t;

   logic                    clk;
   logic                    reset;
   logic                    start;
   logic                    load_en;
   logic [`CADR_PC_W-1:0]   load_addr;
   cadr_pkg::micro_instr_t  load_word;
   logic [`CADR_PC_W:0]     prog_len;
   logic                    busy;
   logic                    result_valid;
   logic                    result_dest_m;
   logic [`CADR_ADDR_W-1:0] result_addr;
   logic [`CADR_DATA_W-1:0] result_data;
   logic [`CADR_PC_W-1:0]   result_pc;

   cadr_pkg::micro_instr_t  prog [1 << `CADR_PC_W];   // Program being built
   logic [`CADR_DATA_W-1:0] ref_a [REGS];              // Model A memory
   logic [`CADR_DATA_W-1:0] ref_m [REGS];              // Model M memory
   expect_t                 exp_q [$];                 // Results still due, pc order
   string                   test_name;
   integer                  seed = 71039;
   int                      checks;
   int                      errors;
   int                      results_seen;              // Results in the current run
   int                      busy_fall_at;              // Results seen when busy dropped

   cadr_core DUT (.*);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(LIMIT_CYCLES * PERIOD);
      $display("Timeout: run still going after %0d cycles in %s", LIMIT_CYCLES, test_name);
      $display("Errors found");
      $finish;
   end

   ////////////////////
   // Reference model

   function automatic logic [`CADR_DATA_W-1:0] model_result(input cadr_pkg::micro_instr_t w);
      logic [`CADR_DATA_W-1:0] a;
      logic [`CADR_DATA_W-1:0] m;
      logic [`CADR_DATA_W-1:0] d;
      a = ref_a[w.a_addr];
      m = ref_m[w.m_addr];
      case (w.op)
         cadr_pkg::OP_ADD:    d = a + m;
         cadr_pkg::OP_SUB:    d = a - m;              // A minus M
         cadr_pkg::OP_AND:    d = a & m;
         cadr_pkg::OP_OR:     d = a | m;
         cadr_pkg::OP_XOR:    d = a ^ m;
         cadr_pkg::OP_PASS_M: d = m;
         cadr_pkg::OP_SHL:    d = m << w.imm[4:0];    // Low five bits only
         cadr_pkg::OP_LOADI:  d = {{(`CADR_DATA_W - `CADR_IMM_W){1'b0}}, w.imm};
         default:             d = '0;
      endcase
      if (w.dest_m) begin
         ref_m[w.dest_addr] = d;
      end else begin
         ref_a[w.dest_addr] = d;
      end
      return d;
   endfunction

   // Random word, registers kept in 0 to 7 so words share them
   function automatic cadr_pkg::micro_instr_t random_word();
      cadr_pkg::micro_instr_t w;
      logic [63:0]            r;
      r = {$random(seed), $random(seed)};
      w = r[$bits(cadr_pkg::micro_instr_t)-1:0];
      w.op = cadr_pkg::alu_op_t'({1'b0, r[62:60]});   // All eight opcodes
      w.dest_addr[`CADR_ADDR_W-1:3] = '0;
      w.a_addr[`CADR_ADDR_W-1:3]    = '0;
      w.m_addr[`CADR_ADDR_W-1:3]    = '0;
      return w;
   endfunction

   ////////////////////
   // Compare tasks

   task automatic check_data(input string what, input logic [`CADR_DATA_W-1:0] exp,
                             input logic [`CADR_DATA_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_addr(input string what, input logic [`CADR_ADDR_W-1:0] exp,
                             input logic [`CADR_ADDR_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      end
   endtask

   task automatic check_pc(input string what, input logic [`CADR_PC_W-1:0] exp,
                           input logic [`CADR_PC_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   ////////////////////
   // Stimulus tasks, all entered on a falling edge

   task automatic apply_reset();
      reset = 1'b1;
      @(posedge clk);
      exp_q.delete();                       // Words in flight are dropped
      for (int i = 0; i < REGS; i++) begin
         ref_a[i] = '0;
         ref_m[i] = '0;
      end
      repeat (RESET_CYCLES) begin
         @(negedge clk);
         check_flag("result_valid in reset", 1'b0, result_valid);
         check_flag("busy in reset", 1'b0, busy);
      end
      reset = 1'b0;
   endtask

   // Writes the control store and queues the expected results in pc order
   task automatic load_program(input int n);
      expect_t e;
      for (int i = 0; i < n; i++) begin
         e.dest_m  = prog[i].dest_m;
         e.addr    = prog[i].dest_addr;
         e.data    = model_result(prog[i]);
         e.pc      = i[`CADR_PC_W-1:0];
         exp_q.push_back(e);
         load_en   = 1'b1;
         load_addr = i[`CADR_PC_W-1:0];
         load_word = prog[i];
         @(negedge clk);
      end
      load_en = 1'b0;
   endtask

   task automatic start_program(input int n);
      results_seen = 0;
      prog_len     = n[`CADR_PC_W:0];
      start        = 1'b1;
      @(negedge clk);
      start        = 1'b0;
   endtask

   task automatic run_program(input int n);
      load_program(n);
      start_program(n);
      busy_fall_at = -1;
      while (exp_q.size() != 0) begin       // Watchdog covers a lost result
         @(negedge clk);
         if (!busy && busy_fall_at < 0) begin
            busy_fall_at = results_seen;
         end
      end
      repeat (2 * CPI) @(negedge clk);      // Room for a stray extra result
      if (results_seen != n) begin
         errors++;
         $display("%s: got %0d results for a %0d word program", test_name, results_seen, n);
      end
      check_flag("busy after run", 1'b0, busy);
   endtask

   ////////////////////
   // Comparator

   always @(negedge clk) begin : compare_results
      expect_t e;
      if (!reset && result_valid) begin
         results_seen++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("%s: result for pc %0d arrived with no word due", test_name, result_pc);
         end else begin
            e = exp_q.pop_front();
            check_flag("dest_m", e.dest_m, result_dest_m);
            check_addr("dest addr", e.addr, result_addr);
            check_data("data", e.data, result_data);
            check_pc("pc tag", e.pc, result_pc);
         end
      end
   end

   ////////////////////
   // Test sequence

   initial begin
      checks    = 0;
      errors    = 0;
      reset     = 1'b1;
      start     = 1'b0;
      load_en   = 1'b0;
      load_addr = '0;
      load_word = '0;
      prog_len  = '0;
      test_name = "power on reset";
      apply_reset();

      test_name = "immediate loads";
      for (int i = 0; i < LEN_LOADI; i++) begin
         prog[i]           = random_word();
         prog[i].op        = cadr_pkg::OP_LOADI;
         prog[i].dest_m    = i[0];                      // Alternate A and M
         prog[i].dest_addr = i[`CADR_ADDR_W-1:0];
      end
      run_program(LEN_LOADI);

      test_name = "random alu";
      for (int i = 0; i < LEN_PRELOAD; i++) begin
         prog[i]                = random_word();
         prog[i].op             = cadr_pkg::OP_LOADI;
         prog[i].dest_m         = i[3];                 // A 0 to 7, then M 0 to 7
         prog[i].dest_addr[2:0] = i[2:0];
      end
      run_program(LEN_PRELOAD);
      for (int i = 0; i < LEN_RANDOM; i++) begin
         prog[i] = random_word();
      end
      run_program(LEN_RANDOM);

      test_name = "read after write";
      for (int i = 0; i < LEN_CHAIN; i++) begin
         prog[i]           = random_word();
         prog[i].op        = (i == 0) ? cadr_pkg::OP_LOADI : cadr_pkg::OP_ADD;
         prog[i].dest_m    = 1'b0;
         prog[i].dest_addr = i[`CADR_ADDR_W-1:0] + 5'd16;
         prog[i].a_addr    = i[`CADR_ADDR_W-1:0] + 5'd15;   // Previous destination
      end
      run_program(LEN_CHAIN);

      test_name = "back pressure";
      for (int i = 0; i < LEN_BURST; i++) begin
         prog[i] = random_word();
      end
      run_program(LEN_BURST);
      // Credits cap the words between store and result port
      if ((busy_fall_at >= 0) &&
          (busy_fall_at < LEN_BURST - `CADR_QUEUE_DEPTH - `CADR_EXEC_SLOTS)) begin
         errors++;
         $display("%s: busy fell after only %0d results, before the last word could issue",
                  test_name, busy_fall_at);
      end

      test_name = "reset mid run";
      for (int i = 0; i < LEN_ABORT; i++) begin
         prog[i] = random_word();
      end
      load_program(LEN_ABORT);
      start_program(LEN_ABORT);
      while (results_seen < 3) @(negedge clk);
      check_flag("busy before reset", 1'b1, busy);
      apply_reset();
      test_name = "zeros after reset";
      for (int i = 0; i < LEN_ZERO; i++) begin
         prog[i]    = random_word();
         prog[i].op = cadr_pkg::OP_PASS_M;              // M reads back cleared
      end
      run_program(LEN_ZERO);

      test_name = "reload";
      for (int i = 0; i < LEN_RELOAD; i++) begin
         prog[i] = random_word();
      end
      run_program(LEN_RELOAD);

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- source/cadr_consts.svh
// Widths, depths and timing of the microcoded core; include wherever these sizes are needed
`ifndef CADR_CONSTS_SVH
`define CADR_CONSTS_SVH

////////////////////
// Data path

`define CADR_DATA_W 32            // ALU and register file width
`define CADR_ADDR_W 5             // A and M memory address
`define CADR_IMM_W 16             // Immediate field of a microword
`define CADR_PC_W 6               // Control store address, 64 words

////////////////////
// Flow control

`define CADR_QUEUE_DEPTH 4        // Queue entries and producer credits
`define CADR_EXEC_SLOTS 1         // Words held by the consumer

////////////////////
// Timing

`define CADR_CYCLES_PER_INSTR 4   // Decode, read, ALU, write

`endif

//--- source/cadr_core.sv
// Top of the microcoded core; load microcode, pulse start, then collect one result per word
`include "cadr_consts.svh"

module cadr_core (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    start,
   input  logic                    load_en,
   input  logic [`CADR_PC_W-1:0]   load_addr,
   input  cadr_pkg::micro_instr_t  load_word,
   input  logic [`CADR_PC_W:0]     prog_len,
   output logic                    busy,
   output logic                    result_valid,
   output logic                    result_dest_m,
   output logic [`CADR_ADDR_W-1:0] result_addr,
   output logic [`CADR_DATA_W-1:0] result_data,
   output logic [`CADR_PC_W-1:0]   result_pc
);

   micro_if fetch_link ();   // Store to queue
   micro_if issue_link ();   // Queue to execution

   ////////////////////
   // Producer

   control_store u_control_store (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .load_en   (load_en),
      .load_addr (load_addr),
      .load_word (load_word),
      .prog_len  (prog_len),
      .busy      (busy),
      .fetch     (fetch_link)
   );

   // Buffer
   instr_queue u_instr_queue (
      .clk   (clk),
      .reset (reset),
      .fetch (fetch_link),
      .issue (issue_link)
   );

   ////////////////////
   // Consumer

   micro_exec u_micro_exec (
      .clk           (clk),
      .reset         (reset),
      .issue         (issue_link),
      .result_valid  (result_valid),
      .result_dest_m (result_dest_m),
      .result_addr   (result_addr),
      .result_data   (result_data),
      .result_pc     (result_pc)
   );

endmodule

//--- source/cadr_pkg.sv
// Shared types of the microcoded core: opcodes, microcycle states and the microword layout
`include "cadr_consts.svh"

package cadr_pkg;

   ////////////////////
   // Opcodes

   typedef enum logic [3:0] {
      OP_ADD    = 4'd0,   // A + M
      OP_SUB    = 4'd1,   // A - M
      OP_AND    = 4'd2,
      OP_OR     = 4'd3,
      OP_XOR    = 4'd4,
      OP_PASS_M = 4'd5,   // M straight through
      OP_SHL    = 4'd6,   // M shifted left by imm[4:0]
      OP_LOADI  = 4'd7    // Zero extended imm
   } alu_op_t;

   ////////////////////
   // Microcycle

   typedef enum logic [1:0] {
      ST_DECODE = 2'd0,   // Waits here when no word is held
      ST_READ   = 2'd1,
      ST_ALU    = 2'd2,
      ST_WRITE  = 2'd3
   } exec_state_t;

   ////////////////////
   // Microword, 36 bits

   typedef struct packed {
      alu_op_t                 op;
      logic                    dest_m;      // 1 writes M, 0 writes A
      logic [`CADR_ADDR_W-1:0] dest_addr;
      logic [`CADR_ADDR_W-1:0] a_addr;
      logic [`CADR_ADDR_W-1:0] m_addr;
      logic [`CADR_IMM_W-1:0]  imm;
   } micro_instr_t;

endpackage

//--- source/control_store.sv
// Loadable microcode store that streams words 0 to prog_len-1 into the queue while credits allow
`include "cadr_consts.svh"

module control_store (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   start,
   input  logic                   load_en,
   input  logic [`CADR_PC_W-1:0]  load_addr,
   input  cadr_pkg::micro_instr_t load_word,
   input  logic [`CADR_PC_W:0]    prog_len,
   output logic                   busy,
   micro_if.sender                fetch
);

   localparam int WORDS  = 1 << `CADR_PC_W;
   localparam int CRED_W = $clog2(`CADR_QUEUE_DEPTH + 1);

   cadr_pkg::micro_instr_t ucode [WORDS];   // Microcode memory

   logic [`CADR_PC_W-1:0] pc;       // Next word to read
   logic                  running;  // Streaming a program
   logic [CRED_W-1:0]     credits;  // Free queue slots
   logic                  issue;    // Word read this cycle
   logic                  last;     // pc sits on the final word

   assign issue = running && (credits != '0);
   assign last  = ({1'b0, pc} == (prog_len - 1'b1));
   assign busy  = running;

   ////////////////////
   // Loading

   always_ff @(posedge clk) begin
      if (load_en && !running) begin   // Program is frozen while streaming
         ucode[load_addr] <= load_word;
      end
   end

   ////////////////////
   // Sequencing

   always_ff @(posedge clk) begin
      if (reset) begin
         running     <= 1'b0;
         pc          <= '0;
         credits     <= CRED_W'(`CADR_QUEUE_DEPTH);   // Queue starts empty
         fetch.valid <= 1'b0;
      end else begin
         fetch.valid <= issue;                        // Read data shows a cycle later
         credits     <= credits - CRED_W'(issue) + CRED_W'(fetch.credit);
         if (!running) begin
            if (start && (prog_len != '0)) begin      // Empty program never runs
               running <= 1'b1;
               pc      <= '0;
            end
         end else if (issue) begin
            pc <= pc + 1'b1;
            if (last) begin
               running <= 1'b0;                       // Final word is on its way
            end
         end
      end
   end

   // Read port feeding the link
   always_ff @(posedge clk) begin
      if (issue) begin
         fetch.word   <= ucode[pc];
         fetch.pc_tag <= pc;
      end
   end

endmodule

//--- source/instr_queue.sv
// Microword FIFO between store and execution unit; credits flow back upstream as words leave
`include "cadr_consts.svh"

module instr_queue (
   input  logic      clk,
   input  logic      reset,
   micro_if.receiver fetch,
   micro_if.sender   issue
);

   localparam int DEPTH  = `CADR_QUEUE_DEPTH;
   localparam int PTR_W  = $clog2(DEPTH);
   localparam int CNT_W  = $clog2(DEPTH + 1);
   localparam int CRED_W = $clog2(`CADR_EXEC_SLOTS + 1);

   cadr_pkg::micro_instr_t word_mem [DEPTH];   // Entry payload
   logic [`CADR_PC_W-1:0]  tag_mem  [DEPTH];   // Entry pc tags

   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;      // Occupied entries
   logic [CRED_W-1:0] credits;    // Free execution slots
   logic              push;
   logic              send;
   logic              credit_ok;

   assign push = fetch.valid;     // Upstream credits keep this off when full

   // A credit returning this cycle counts at once so the consumer never idles
   assign credit_ok = (credits != '0) || issue.credit;
   assign send      = (count != '0) && credit_ok;

   ////////////////////
   // Outgoing link

   assign issue.valid  = send;
   assign issue.word   = word_mem[rd_ptr];    // Oldest entry
   assign issue.pc_tag = tag_mem[rd_ptr];
   assign fetch.credit = send;                // Slot freed as the word leaves

   ////////////////////
   // Storage

   always_ff @(posedge clk) begin
      if (push) begin
         word_mem[wr_ptr] <= fetch.word;
         tag_mem[wr_ptr]  <= fetch.pc_tag;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         credits <= CRED_W'(`CADR_EXEC_SLOTS);
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (send) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count   <= count + CNT_W'(push) - CNT_W'(send);
         credits <= credits + CRED_W'(issue.credit) - CRED_W'(send);
      end
   end

endmodule

//--- source/micro_exec.sv
// Execution unit running each microword through decode, read, ALU and write on the A and M memories
`include "cadr_consts.svh"

module micro_exec (
   input  logic                    clk,
   input  logic                    reset,
   micro_if.receiver               issue,
   output logic                    result_valid,
   output logic                    result_dest_m,
   output logic [`CADR_ADDR_W-1:0] result_addr,
   output logic [`CADR_DATA_W-1:0] result_data,
   output logic [`CADR_PC_W-1:0]   result_pc
);

   localparam int REGS  = 1 << `CADR_ADDR_W;
   localparam int ZEXT  = `CADR_DATA_W - `CADR_IMM_W;

   cadr_pkg::exec_state_t  state;

   cadr_pkg::micro_instr_t pend_word;    // Slot filled from the link
   logic [`CADR_PC_W-1:0]  pend_pc;
   logic                   pend_valid;
   cadr_pkg::micro_instr_t ir;           // Word in the microcycle
   logic [`CADR_PC_W-1:0]  ir_pc;

   logic [`CADR_DATA_W-1:0] a_mem [REGS];
   logic [`CADR_DATA_W-1:0] m_mem [REGS];
   logic [`CADR_DATA_W-1:0] a_val;       // A latch
   logic [`CADR_DATA_W-1:0] m_val;       // M latch
   logic [`CADR_DATA_W-1:0] alu_d;
   logic [`CADR_DATA_W-1:0] alu_q;       // Output bus register

   ////////////////////
   // Microcycle FSM

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= cadr_pkg::ST_DECODE;
         pend_valid <= 1'b0;
      end else begin
         case (state)
            cadr_pkg::ST_DECODE: if (pend_valid) state <= cadr_pkg::ST_READ;
            cadr_pkg::ST_READ:   state <= cadr_pkg::ST_ALU;
            cadr_pkg::ST_ALU:    state <= cadr_pkg::ST_WRITE;
            default:             state <= cadr_pkg::ST_DECODE;
         endcase
         if (issue.valid) begin
            pend_valid <= 1'b1;                    // Single slot, never refused
         end else if (state == cadr_pkg::ST_DECODE) begin
            pend_valid <= 1'b0;                    // Taken by decode
         end
      end
   end

   ////////////////////
   // Data path

   always_ff @(posedge clk) begin
      if (issue.valid) begin
         pend_word <= issue.word;
         pend_pc   <= issue.pc_tag;
      end
      if ((state == cadr_pkg::ST_DECODE) && pend_valid) begin
         ir    <= pend_word;                      // Latch for the whole cycle
         ir_pc <= pend_pc;
      end
      if (state == cadr_pkg::ST_READ) begin
         a_val <= a_mem[ir.a_addr];
         m_val <= m_mem[ir.m_addr];
      end
      if (state == cadr_pkg::ST_ALU) begin
         alu_q <= alu_d;
      end
   end

   always_comb begin
      case (ir.op)
         cadr_pkg::OP_ADD:    alu_d = a_val + m_val;
         cadr_pkg::OP_SUB:    alu_d = a_val - m_val;   // A minus M
         cadr_pkg::OP_AND:    alu_d = a_val & m_val;
         cadr_pkg::OP_OR:     alu_d = a_val | m_val;
         cadr_pkg::OP_XOR:    alu_d = a_val ^ m_val;
         cadr_pkg::OP_PASS_M: alu_d = m_val;
         cadr_pkg::OP_SHL:    alu_d = m_val << ir.imm[4:0];
         cadr_pkg::OP_LOADI:  alu_d = {{ZEXT{1'b0}}, ir.imm};
         default:             alu_d = '0;              // Unused encodings
      endcase
   end

   ////////////////////
   // Register files

   // Both memories read back zero after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < REGS; i++) begin
            a_mem[i] <= '0;
            m_mem[i] <= '0;
         end
      end else if (result_valid) begin
         if (ir.dest_m) begin
            m_mem[ir.dest_addr] <= alu_q;
         end else begin
            a_mem[ir.dest_addr] <= alu_q;
         end
      end
   end

   // Result port and credit in the write state
   assign result_valid  = (state == cadr_pkg::ST_WRITE);
   assign issue.credit  = result_valid;          // Slot free for the next word
   assign result_dest_m = ir.dest_m;
   assign result_addr   = ir.dest_addr;
   assign result_data   = alu_q;
   assign result_pc     = ir_pc;

endmodule

//--- source/micro_if.sv
// One credit controlled microword link; the sender owns the credit count, the receiver returns credits
`include "cadr_consts.svh"

interface micro_if;

   // Payload
   cadr_pkg::micro_instr_t word;     // Microword
   logic [`CADR_PC_W-1:0]  pc_tag;   // Control store address of the word

   // Handshake
   logic valid;                      // One cycle per word, spends a credit
   logic credit;                     // One cycle per freed slot

   modport sender (
      output word,
      output pc_tag,
      output valid,
      input  credit
   );

   modport receiver (
      input  word,
      input  pc_tag,
      input  valid,
      output credit
   );

endinterface
